/* hdl/memPkg.sv */
package memPkg;

  // word width on both core ports and on the bus
  parameter int wordWidth = 32;

  // byte addresses everywhere, memory and caches drop the low bits
  parameter int addrWidth = 32;

  // one lane per byte of a word
  parameter int maskWidth = wordWidth / 8;

  // per-lane write enable for stores
  typedef logic [maskWidth-1:0] byteMaskT;

  // every lane enabled, driven on instruction beats
  parameter byteMaskT fullMask = '1;

  // kind of a single bus beat, carried on busWrite
  typedef enum logic {
    kindRead  = 1'b0,
    kindWrite = 1'b1
  } busKindT;

  // overlay the masked lanes of newWord onto oldWord
  // used by the data cache on a store hit and by the memory on a write beat
  function automatic logic [wordWidth-1:0] mergeBytes(
    input logic [wordWidth-1:0] oldWord,
    input logic [wordWidth-1:0] newWord,
    input byteMaskT             mask
  );
    logic [wordWidth-1:0] merged;
    merged = oldWord;
    for (int lane = 0; lane < maskWidth; lane++) begin
      if (mask[lane]) begin
        merged[lane*8 +: 8] = newWord[lane*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* hdl/instrCache.sv */
`timescale 1ns/100ps

module instrCache #(
  parameter int wordsPerLine = 4,
  parameter int lineCount    = 16
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         instrReq,
  input  logic [memPkg::addrWidth-1:0] instrAddr,
  output logic [memPkg::wordWidth-1:0] instrData,
  output logic                         instrStall,
  output logic                         busReqI,
  output logic [memPkg::addrWidth-1:0] busAddrI,
  input  logic                         busReadyI,
  input  logic [memPkg::wordWidth-1:0] busRdata
);

  // address split: tag | line index | word offset | byte
  localparam int byteBits   = $clog2(memPkg::maskWidth);
  localparam int offsetBits = $clog2(wordsPerLine);
  localparam int indexBits  = $clog2(lineCount);
  localparam int tagBits    = memPkg::addrWidth - byteBits - offsetBits - indexBits;

  typedef enum logic {
    icIdle,
    icRefill
  } stateT;

  stateT                        state;
  logic [offsetBits-1:0]        wordCnt;
  logic [lineCount-1:0]         valid;
  logic [tagBits-1:0]           tagArr [lineCount];
  // words of line n sit at n*wordsPerLine .. n*wordsPerLine+wordsPerLine-1
  logic [memPkg::wordWidth-1:0] dataArr [lineCount*wordsPerLine];

  logic [offsetBits-1:0]        offset;
  logic [indexBits-1:0]         index;
  logic [tagBits-1:0]           tag;
  logic                         hit;

  assign offset = instrAddr[byteBits +: offsetBits];
  assign index  = instrAddr[byteBits+offsetBits +: indexBits];
  assign tag    = instrAddr[memPkg::addrWidth-1 -: tagBits];

  assign hit = valid[index] && (tagArr[index] == tag);

  // hit path, word out in the fetch cycle
  assign instrData = dataArr[{index, offset}];

  // stall from the miss cycle until the cycle after the last beat
  assign instrStall = (state == icRefill) || (instrReq && !hit);

  // fetch address is held by the core, so the refill reuses its tag and index
  assign busReqI  = (state == icRefill);
  assign busAddrI = {tag, index, wordCnt, {byteBits{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= icIdle;
      wordCnt <= '0;
      valid   <= '0;
    end else begin
      case (state)
        icIdle: begin
          if (instrReq && !hit) begin
            state        <= icRefill;
            wordCnt      <= '0;
            // line is invalid while it is partly overwritten
            valid[index] <= 1'b0;
          end
        end
        icRefill: begin
          if (busReadyI) begin
            wordCnt <= wordCnt + 1'b1;
            if (wordCnt == offsetBits'(wordsPerLine - 1)) begin
              valid[index] <= 1'b1;
              state        <= icIdle;
            end
          end
        end
      endcase
    end
  end

  // line fill, one word per ready beat
  always_ff @(posedge clk) begin
    if (state == icRefill && busReadyI) begin
      dataArr[{index, wordCnt}] <= busRdata;
      tagArr[index]             <= tag;
    end
  end

endmodule

/* hdl/dataCache.sv */
`timescale 1ns/100ps

module dataCache #(
  parameter int wordsPerLine = 4,
  parameter int lineCount    = 16
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         dataRead,
  input  logic                         dataWrite,
  input  logic [memPkg::addrWidth-1:0] dataAddr,
  input  logic [memPkg::wordWidth-1:0] dataWdata,
  input  memPkg::byteMaskT             byteMask,
  output logic [memPkg::wordWidth-1:0] dataRdata,
  output logic                         dataStall,
  output logic                         busReqD,
  output logic [memPkg::addrWidth-1:0] busAddrD,
  output memPkg::busKindT              busWriteD,
  output logic [memPkg::wordWidth-1:0] busWdataD,
  output memPkg::byteMaskT             busMaskD,
  input  logic                         busReadyD,
  input  logic [memPkg::wordWidth-1:0] busRdata
);

  // same address split as the instruction side
  localparam int byteBits   = $clog2(memPkg::maskWidth);
  localparam int offsetBits = $clog2(wordsPerLine);
  localparam int indexBits  = $clog2(lineCount);
  localparam int tagBits    = memPkg::addrWidth - byteBits - offsetBits - indexBits;

  typedef enum logic [1:0] {
    dcIdle,
    dcRefill,
    dcStore
  } stateT;

  stateT                        state;
  logic [offsetBits-1:0]        wordCnt;
  logic [lineCount-1:0]         valid;
  logic [tagBits-1:0]           tagArr [lineCount];
  logic [memPkg::wordWidth-1:0] dataArr [lineCount*wordsPerLine];

  logic [offsetBits-1:0]        offset;
  logic [indexBits-1:0]         index;
  logic [tagBits-1:0]           tag;
  logic                         hit;
  logic                         lastBeat;

  assign offset = dataAddr[byteBits +: offsetBits];
  assign index  = dataAddr[byteBits+offsetBits +: indexBits];
  assign tag    = dataAddr[memPkg::addrWidth-1 -: tagBits];

  assign hit      = valid[index] && (tagArr[index] == tag);
  assign lastBeat = (wordCnt == offsetBits'(wordsPerLine - 1));

  // load hit data, valid when the stall is low
  assign dataRdata = dataArr[{index, offset}];

  always_comb begin
    case (state)
      dcRefill: dataStall = 1'b1;
      // store ends in the cycle of its write beat's ready
      dcStore:  dataStall = !busReadyD;
      // any store and any load miss stall from the request cycle
      default:  dataStall = dataWrite || (dataRead && !hit);
    endcase
  end

  // one store beat at the core's own word, or refill beats walking the line
  assign busReqD   = (state != dcIdle);
  assign busWriteD = (state == dcStore) ? memPkg::kindWrite : memPkg::kindRead;
  assign busAddrD  = {tag, index, (state == dcStore) ? offset : wordCnt,
                      {byteBits{1'b0}}};
  // core holds store data and mask until the stall drops
  assign busWdataD = dataWdata;
  assign busMaskD  = byteMask;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= dcIdle;
      wordCnt <= '0;
      valid   <= '0;
    end else begin
      case (state)
        dcIdle: begin
          if (dataWrite) begin
            // write-through, no allocate on a miss
            state <= dcStore;
          end else if (dataRead && !hit) begin
            state        <= dcRefill;
            wordCnt      <= '0;
            valid[index] <= 1'b0;
          end
        end
        dcRefill: begin
          if (busReadyD) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastBeat) begin
              valid[index] <= 1'b1;
              state        <= dcIdle;
            end
          end
        end
        dcStore: begin
          if (busReadyD) begin
            state <= dcIdle;
          end
        end
        default: state <= dcIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == dcRefill && busReadyD) begin
      dataArr[{index, wordCnt}] <= busRdata;
      tagArr[index]             <= tag;
    end else if (state == dcStore && busReadyD && hit) begin
      // store hit keeps the cached copy in step with memory
      dataArr[{index, offset}] <= memPkg::mergeBytes(dataArr[{index, offset}],
                                                     dataWdata, byteMask);
    end
  end

endmodule

/* hdl/busArbiter.sv */
`timescale 1ns/100ps

module busArbiter (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         busReqI,
  input  logic [memPkg::addrWidth-1:0] busAddrI,
  input  logic                         busReqD,
  input  logic [memPkg::addrWidth-1:0] busAddrD,
  input  memPkg::busKindT              busWriteD,
  input  logic [memPkg::wordWidth-1:0] busWdataD,
  input  memPkg::byteMaskT             busMaskD,
  output logic                         busReadyI,
  output logic                         busReadyD,
  output logic                         busReq,
  output logic [memPkg::addrWidth-1:0] busAddr,
  output memPkg::busKindT              busWrite,
  output logic [memPkg::wordWidth-1:0] busWdata,
  output memPkg::byteMaskT             busMask,
  input  logic                         busReady
);

  typedef enum logic [1:0] {
    ownNone,
    ownInstr,
    ownData
  } ownerT;

  // owner is last cycle's grant, grant is this cycle's
  ownerT owner;
  ownerT grant;

  always_comb begin
    if (owner == ownInstr && busReqI) begin
      // instruction refill in progress keeps the bus
      grant = ownInstr;
    end else if (busReqD) begin
      // data side first on a free bus, and keeps it while requesting
      grant = ownData;
    end else if (busReqI) begin
      grant = ownInstr;
    end else begin
      grant = ownNone;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      owner <= ownNone;
    end else begin
      owner <= grant;
    end
  end

  // request fields of the granted cache onto the shared bus
  assign busReq   = (grant != ownNone);
  assign busAddr  = (grant == ownData) ? busAddrD : busAddrI;
  assign busWrite = (grant == ownData) ? busWriteD : memPkg::kindRead;
  assign busWdata = busWdataD;
  assign busMask  = (grant == ownData) ? busMaskD : memPkg::fullMask;

  // ready goes to the owner only
  assign busReadyI = busReady && (grant == ownInstr);
  assign busReadyD = busReady && (grant == ownData);

endmodule

/* hdl/busMemory.sv */
`timescale 1ns/100ps

module busMemory #(
  parameter int memWords   = 4096,
  parameter int memLatency = 2
) (
  input  logic                         clk,
  input  logic                         busReq,
  input  logic [memPkg::addrWidth-1:0] busAddr,
  input  memPkg::busKindT              busWrite,
  input  logic [memPkg::wordWidth-1:0] busWdata,
  input  memPkg::byteMaskT             byteMask,
  output logic [memPkg::wordWidth-1:0] busRdata,
  output logic                         busReady
);

  localparam int byteBits = $clog2(memPkg::maskWidth);
  localparam int wordBits = $clog2(memWords);
  localparam int cntBits  = $clog2(memLatency + 1);

  // contents start cleared
  logic [memPkg::wordWidth-1:0] mem [memWords] = '{default: '0};
  logic [cntBits-1:0]           latCnt = '0;
  logic [wordBits-1:0]          wordIdx;

  // word index from the byte address, upper bits ignored
  assign wordIdx = busAddr[byteBits +: wordBits];

  // counter is 0 in the first request cycle
  // so ready lands memLatency cycles later
  assign busReady = busReq && (latCnt == cntBits'(memLatency));

  // read data is valid in the ready cycle
  assign busRdata = mem[wordIdx];

  always_ff @(posedge clk) begin
    if (!busReq || busReady) begin
      // idle bus or beat done, next beat counts from zero
      latCnt <= '0;
    end else begin
      latCnt <= latCnt + 1'b1;
    end
  end

  // write beat lands at the end of its ready cycle
  always_ff @(posedge clk) begin
    if (busReady && busWrite == memPkg::kindWrite) begin
      mem[wordIdx] <= memPkg::mergeBytes(mem[wordIdx], busWdata, byteMask);
    end
  end

endmodule

/* hdl/memSystem.sv */
`timescale 1ns/100ps

module memSystem #(
  parameter int wordsPerLine = 4,
  parameter int lineCount    = 16,
  parameter int memWords     = 4096,
  parameter int memLatency   = 2
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         instrReq,
  input  logic [memPkg::addrWidth-1:0] instrAddr,
  output logic [memPkg::wordWidth-1:0] instrData,
  output logic                         instrStall,
  input  logic                         dataRead,
  input  logic                         dataWrite,
  input  logic [memPkg::addrWidth-1:0] dataAddr,
  input  logic [memPkg::wordWidth-1:0] dataWdata,
  input  memPkg::byteMaskT             byteMask,
  output logic [memPkg::wordWidth-1:0] dataRdata,
  output logic                         dataStall
);

  // cache side of the arbiter
  logic                         busReqI;
  logic                         busReqD;
  logic [memPkg::addrWidth-1:0] busAddrI;
  logic [memPkg::addrWidth-1:0] busAddrD;
  memPkg::busKindT              busWriteD;
  logic [memPkg::wordWidth-1:0] busWdataD;
  memPkg::byteMaskT             busMaskD;
  logic                         busReadyI;
  logic                         busReadyD;

  // shared bus toward memory, busRdata fans out to both caches
  logic                         busReq;
  logic [memPkg::addrWidth-1:0] busAddr;
  memPkg::busKindT              busWrite;
  logic [memPkg::wordWidth-1:0] busWdata;
  memPkg::byteMaskT             busMask;
  logic [memPkg::wordWidth-1:0] busRdata;
  logic                         busReady;

  instrCache #(
    .wordsPerLine(wordsPerLine),
    .lineCount   (lineCount)
  ) i_instrCache (
    .clk       (clk),
    .rstN      (rstN),
    .instrReq  (instrReq),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .instrStall(instrStall),
    .busReqI   (busReqI),
    .busAddrI  (busAddrI),
    .busReadyI (busReadyI),
    .busRdata  (busRdata)
  );

  dataCache #(
    .wordsPerLine(wordsPerLine),
    .lineCount   (lineCount)
  ) i_dataCache (
    .clk      (clk),
    .rstN     (rstN),
    .dataRead (dataRead),
    .dataWrite(dataWrite),
    .dataAddr (dataAddr),
    .dataWdata(dataWdata),
    .byteMask (byteMask),
    .dataRdata(dataRdata),
    .dataStall(dataStall),
    .busReqD  (busReqD),
    .busAddrD (busAddrD),
    .busWriteD(busWriteD),
    .busWdataD(busWdataD),
    .busMaskD (busMaskD),
    .busReadyD(busReadyD),
    .busRdata (busRdata)
  );

  busArbiter i_busArbiter (
    .clk      (clk),
    .rstN     (rstN),
    .busReqI  (busReqI),
    .busAddrI (busAddrI),
    .busReqD  (busReqD),
    .busAddrD (busAddrD),
    .busWriteD(busWriteD),
    .busWdataD(busWdataD),
    .busMaskD (busMaskD),
    .busReadyI(busReadyI),
    .busReadyD(busReadyD),
    .busReq   (busReq),
    .busAddr  (busAddr),
    .busWrite (busWrite),
    .busWdata (busWdata),
    .busMask  (busMask),
    .busReady (busReady)
  );

  busMemory #(
    .memWords  (memWords),
    .memLatency(memLatency)
  ) i_busMemory (
    .clk     (clk),
    .busReq  (busReq),
    .busAddr (busAddr),
    .busWrite(busWrite),
    .busWdata(busWdata),
    .byteMask(busMask),
    .busRdata(busRdata),
    .busReady(busReady)
  );

endmodule

/* bench/memSystem_assert.sv */
`timescale 1ns/100ps

module memSystemAssert (
  input logic       clk,
  input logic       rstN,
  input logic       busReqI,
  input logic       busReqD,
  input logic       busReadyI,
  input logic       busReadyD,
  input logic       busReq,
  input logic       busReady,
  input logic [1:0] owner
);

  // owner encoding inside the arbiter
  localparam logic [1:0] ownInstr = 2'd1;
  localparam logic [1:0] ownData  = 2'd2;

  // failures, read by the testbench for its closing line
  int assertErrors = 0;

  // shared bus answers one cache per beat
  oneReady: assert property (@(posedge clk) disable iff (!rstN)
    !(busReadyI && busReadyD))
    else begin
      $error("both cache readies are high in the same cycle");
      assertErrors++;
    end

  // memory never answers a beat nobody asked for, nor in the beat's first cycle
  readyNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    busReady |-> (busReq && $past(busReq)))
    else begin
      $error("bus ready is high without a request held since the previous cycle");
      assertErrors++;
    end

  // a refill is never split between the caches
  instrKeepsBus: assert property (@(posedge clk) disable iff (!rstN)
    (owner == ownInstr && busReqI) |=> (owner == ownInstr))
    else begin
      $error("instruction cache lost the bus while still requesting");
      assertErrors++;
    end

  dataKeepsBus: assert property (@(posedge clk) disable iff (!rstN)
    (owner == ownData && busReqD) |=> (owner == ownData))
    else begin
      $error("data cache lost the bus while still requesting");
      assertErrors++;
    end

  // quiet bus while reset is held
  resetQuiet: assert property (@(posedge clk)
    !rstN |-> (!busReadyI && !busReadyD))
    else begin
      $error("a cache ready is high during reset");
      assertErrors++;
    end

endmodule

/* bench/memChecker.sv */
`timescale 1ns/100ps

module memChecker (
  input  logic                         clk,
  input  logic                         rstN,
  input  int                           testId,
  input  logic                         instrReq,
  input  logic [memPkg::addrWidth-1:0] instrAddr,
  input  logic [memPkg::wordWidth-1:0] instrData,
  input  logic                         instrStall,
  input  logic                         dataRead,
  input  logic                         dataWrite,
  input  logic [memPkg::addrWidth-1:0] dataAddr,
  input  logic [memPkg::wordWidth-1:0] dataWdata,
  input  memPkg::byteMaskT             byteMask,
  input  logic [memPkg::wordWidth-1:0] dataRdata,
  input  logic                         dataStall,
  output int                           errorCount
);

  // shadow memory by word address, words never stored read as zero
  logic [memPkg::wordWidth-1:0] shadow [int];

  int errors = 0;

  assign errorCount = errors;

  function automatic string testName(input int id);
    case (id)
      1:       return "reset";
      2:       return "storeLoad";
      3:       return "byteMask";
      4:       return "fetch";
      5:       return "concurrent";
      default: return "idle";
    endcase
  endfunction

  // expected word at a byte address
  function automatic logic [memPkg::wordWidth-1:0] expectedWord(
    input logic [memPkg::addrWidth-1:0] addr
  );
    int key;
    key = int'(addr >> 2);
    if (shadow.exists(key)) begin
      return shadow[key];
    end
    return '0;
  endfunction

  // widen each lane enable to 8 bits and blend the two words
  function automatic logic [memPkg::wordWidth-1:0] laneBlend(
    input logic [memPkg::wordWidth-1:0] oldWord,
    input logic [memPkg::wordWidth-1:0] newWord,
    input memPkg::byteMaskT             mask
  );
    logic [memPkg::wordWidth-1:0] bitMask;
    bitMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (oldWord & ~bitMask) | (newWord & bitMask);
  endfunction

  // mid-cycle sampling, all inputs and outputs are settled here
  always @(negedge clk) begin
    if (rstN) begin
      // a stall only ever answers a pending access
      if (instrStall && !instrReq) begin
        errors++;
        $display("test %s: instruction stall is high with no fetch pending",
                 testName(testId));
      end
      if (dataStall && !dataRead && !dataWrite) begin
        errors++;
        $display("test %s: data stall is high with no load or store pending",
                 testName(testId));
      end
      // fetch done this cycle
      if (instrReq && !instrStall) begin
        if (instrData !== expectedWord(instrAddr)) begin
          errors++;
          $display("mismatch test=%s fetch addr=%h expected=%h actual=%h",
                   testName(testId), instrAddr, expectedWord(instrAddr), instrData);
        end
      end
      // load done this cycle
      if (dataRead && !dataStall) begin
        if (dataRdata !== expectedWord(dataAddr)) begin
          errors++;
          $display("mismatch test=%s load addr=%h expected=%h actual=%h",
                   testName(testId), dataAddr, expectedWord(dataAddr), dataRdata);
        end
      end
      // store beat accepted, memory takes it at the next edge
      if (dataWrite && !dataStall) begin
        shadow[int'(dataAddr >> 2)] = laneBlend(expectedWord(dataAddr), dataWdata, byteMask);
      end
    end
  end

endmodule

/* bench/memSystemTb.sv */
`timescale 1ns/100ps

module memSystemTb;

  localparam int wordsPerLine = 4;
  localparam int lineCount    = 16;
  localparam int memWords     = 4096;
  localparam int memLatency   = 2;

  localparam logic [31:0] seed = 32'hbf7d_9543;
  // instructions in the low half of memory, data in the high half
  localparam int regionBytes = memWords * memPkg::maskWidth / 2;
  localparam logic [memPkg::addrWidth-1:0] dataBase = regionBytes;
  // stride between two addresses with the same line index
  localparam int cacheBytes = lineCount * wordsPerLine * memPkg::maskWidth;

  localparam int storeLoadCount  = 24;
  localparam int maskedCount     = 12;
  localparam int fetchCount      = 16;
  localparam int concurrentCount = 24;
  localparam int accessTotal = 2 * storeLoadCount + 5 + 5 * maskedCount
                             + 3 * fetchCount + 2 * concurrentCount;
  // worst case per access is a full refill plus the hit cycle
  localparam int timeoutLimit = 8 + accessTotal * (wordsPerLine + 1) * (memLatency + 2) + 200;

  logic                         clk;
  logic                         rstN;
  logic                         instrReq;
  logic [memPkg::addrWidth-1:0] instrAddr;
  logic [memPkg::wordWidth-1:0] instrData;
  logic                         instrStall;
  logic                         dataRead;
  logic                         dataWrite;
  logic [memPkg::addrWidth-1:0] dataAddr;
  logic [memPkg::wordWidth-1:0] dataWdata;
  memPkg::byteMaskT             byteMask;
  logic [memPkg::wordWidth-1:0] dataRdata;
  logic                         dataStall;

  int          testId;
  int          checkErrors;
  int          benchErrors = 0;
  int          cycleCount  = 0;
  logic [31:0] rngState    = seed;

  // stimulus scratch, filled before each test
  logic [memPkg::addrWidth-1:0] addrList [storeLoadCount];
  logic [memPkg::addrWidth-1:0] fetchAddrs [fetchCount];
  logic [memPkg::addrWidth-1:0] concFetch [concurrentCount];
  logic [memPkg::addrWidth-1:0] concData [concurrentCount/2];
  logic [memPkg::wordWidth-1:0] concWord [concurrentCount/2];
  logic [memPkg::addrWidth-1:0] hitAddr;
  logic [memPkg::addrWidth-1:0] missAddr;
  logic [31:0]                  rnd;
  logic [31:0]                  rnd2;

  memSystem #(
    .wordsPerLine(wordsPerLine),
    .lineCount   (lineCount),
    .memWords    (memWords),
    .memLatency  (memLatency)
  ) i_memSystem (
    .clk       (clk),
    .rstN      (rstN),
    .instrReq  (instrReq),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .instrStall(instrStall),
    .dataRead  (dataRead),
    .dataWrite (dataWrite),
    .dataAddr  (dataAddr),
    .dataWdata (dataWdata),
    .byteMask  (byteMask),
    .dataRdata (dataRdata),
    .dataStall (dataStall)
  );

  memChecker i_memChecker (
    .clk       (clk),
    .rstN      (rstN),
    .testId    (testId),
    .instrReq  (instrReq),
    .instrAddr (instrAddr),
    .instrData (instrData),
    .instrStall(instrStall),
    .dataRead  (dataRead),
    .dataWrite (dataWrite),
    .dataAddr  (dataAddr),
    .dataWdata (dataWdata),
    .byteMask  (byteMask),
    .dataRdata (dataRdata),
    .dataStall (dataStall),
    .errorCount(checkErrors)
  );

  bind busArbiter memSystemAssert busProtocolCheck (
    .clk      (clk),
    .rstN     (rstN),
    .busReqI  (busReqI),
    .busReqD  (busReqD),
    .busReadyI(busReadyI),
    .busReadyD(busReadyD),
    .busReq   (busReq),
    .busReady (busReady),
    .owner    (owner)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // word aligned addresses inside each region
  function automatic logic [memPkg::addrWidth-1:0] randInstrAddr();
    return (nextRand() % regionBytes) & 32'hffff_fffc;
  endfunction

  function automatic logic [memPkg::addrWidth-1:0] randDataAddr();
    return dataBase + ((nextRand() % regionBytes) & 32'hffff_fffc);
  endfunction

  // other data address on the same line index, different tag
  function automatic logic [memPkg::addrWidth-1:0] sameIndexAddr(
    input logic [memPkg::addrWidth-1:0] addr
  );
    return dataBase + ((addr - dataBase + cacheBytes) % regionBytes);
  endfunction

  // called right after a rising edge, returns on the edge that ends the access
  task automatic waitDone(input bit instrSide);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = instrSide ? !instrStall : !dataStall;
      @(posedge clk);
    end
  endtask

  task automatic storeWord(input logic [31:0] addr, input logic [31:0] word,
                           input memPkg::byteMaskT mask);
    dataWrite <= 1'b1;
    dataAddr  <= addr;
    dataWdata <= word;
    byteMask  <= mask;
    waitDone(1'b0);
    dataWrite <= 1'b0;
  endtask

  task automatic loadWord(input logic [31:0] addr);
    dataRead <= 1'b1;
    dataAddr <= addr;
    waitDone(1'b0);
    dataRead <= 1'b0;
  endtask

  task automatic fetchWord(input logic [31:0] addr);
    instrReq  <= 1'b1;
    instrAddr <= addr;
    waitDone(1'b1);
    instrReq  <= 1'b0;
  endtask

  task automatic finishRun();
    int assertErrors;
    int totalErrors;
    assertErrors = i_memSystem.i_busArbiter.busProtocolCheck.assertErrors;
    totalErrors = checkErrors + assertErrors + benchErrors;
    $display("errors: %0d (checker %0d, assertions %0d, bench %0d)",
             totalErrors, checkErrors, assertErrors, benchErrors);
    if (totalErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // hang guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      benchErrors++;
      $display("timeout: accesses still pending after %0d cycles", timeoutLimit);
      finishRun();
    end
  end

  initial begin
    rstN      <= 1'b0;
    instrReq  <= 1'b0;
    instrAddr <= '0;
    dataRead  <= 1'b0;
    dataWrite <= 1'b0;
    dataAddr  <= '0;
    dataWdata <= '0;
    byteMask  <= '0;
    testId    <= 0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    // idle core after reset, checker flags any stall
    testId <= 1;
    repeat (4) @(posedge clk);

    // whole words, then reads back through refill and hits
    testId <= 2;
    for (int i = 0; i < storeLoadCount; i++) begin
      addrList[i] = randDataAddr();
      rnd = nextRand();
      storeWord(addrList[i], rnd, '1);
    end
    for (int i = 0; i < storeLoadCount; i++) begin
      loadWord(addrList[i]);
    end
    // two lines fighting over one index
    hitAddr  = randDataAddr();
    missAddr = sameIndexAddr(hitAddr);
    rnd = nextRand();
    storeWord(hitAddr, rnd, '1);
    rnd = nextRand();
    storeWord(missAddr, rnd, '1);
    loadWord(hitAddr);
    loadWord(missAddr);
    loadWord(hitAddr);

    // random lane masks on a cached line and on an evicting one
    testId <= 3;
    for (int i = 0; i < maskedCount; i++) begin
      hitAddr  = randDataAddr();
      missAddr = sameIndexAddr(hitAddr);
      loadWord(hitAddr);
      rnd  = nextRand();
      rnd2 = nextRand();
      storeWord(hitAddr, rnd, rnd2[3:0]);
      rnd  = nextRand();
      rnd2 = nextRand();
      storeWord(missAddr, rnd, rnd2[3:0]);
      loadWord(hitAddr);
      loadWord(missAddr);
    end

    // program words written through the data side, then fetched twice
    testId <= 4;
    for (int i = 0; i < fetchCount; i++) begin
      fetchAddrs[i] = randInstrAddr();
      rnd = nextRand();
      storeWord(fetchAddrs[i], rnd, '1);
    end
    for (int i = 0; i < fetchCount; i++) begin
      fetchWord(fetchAddrs[i]);
    end
    for (int i = 0; i < fetchCount; i++) begin
      fetchWord(fetchAddrs[i]);
    end

    // both ports busy together, stimulus drawn before the threads start
    testId <= 5;
    for (int i = 0; i < concurrentCount; i++) begin
      concFetch[i] = (i % 2 == 0) ? fetchAddrs[i % fetchCount] : randInstrAddr();
    end
    for (int i = 0; i < concurrentCount / 2; i++) begin
      concData[i] = randDataAddr();
      concWord[i] = nextRand();
    end
    fork
      begin
        for (int i = 0; i < concurrentCount; i++) begin
          fetchWord(concFetch[i]);
        end
      end
      begin
        for (int i = 0; i < concurrentCount / 2; i++) begin
          storeWord(concData[i], concWord[i], '1);
          loadWord(concData[i]);
        end
      end
    join

    repeat (4) @(posedge clk);
    finishRun();
  end

endmodule

/* flist.f */
hdl/memPkg.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/busArbiter.sv
hdl/busMemory.sv
hdl/memSystem.sv
bench/memSystem_assert.sv
bench/memChecker.sv
bench/memSystemTb.sv

/* Bender.yml */
package:
  name: mem_system

sources:
  - files:
      - hdl/memPkg.sv
      - hdl/instrCache.sv
      - hdl/dataCache.sv
      - hdl/busArbiter.sv
      - hdl/busMemory.sv
      - hdl/memSystem.sv
  - target: test
    files:
      - bench/memSystem_assert.sv
      - bench/memChecker.sv
      - bench/memSystemTb.sv
